// File: design/tu_pkg.sv
package tu_pkg;

    // TLB geometry.
    localparam int TLB_ENTRIES = 16;
    localparam int TLB_INDEX_W = 4;

    localparam int VPN2_W = 19;
    localparam int PFN_W  = 20;
    localparam int ASID_W = 8;
    localparam int CACHE_W = 3;

    // entryhi: vpn2 in 31:13, asid in 7:0.
    localparam int ENTRYHI_VPN2_LSB = 13;
    localparam int ENTRYHI_ASID_LSB = 0;

    // entrylo: pfn in 25:6, c in 5:3, then d, v and g.
    localparam int ENTRYLO_PFN_LSB = 6;
    localparam int ENTRYLO_C_LSB   = 3;
    localparam int ENTRYLO_D_BIT   = 2;
    localparam int ENTRYLO_V_BIT   = 1;
    localparam int ENTRYLO_G_BIT   = 0;

    localparam int INDEX_P_BIT = 31; // set by tlbp when nothing matched.

    // every other c code is treated as uncached.
    localparam logic [CACHE_W-1:0] CACHE_CACHEABLE = 3'd3;

    // kseg0 and kseg1 both fold onto the low 512 MB.
    localparam logic [31:0] KSEG_DIRECT_MASK = 32'h1fff_ffff;

    // one entry maps an even/odd pair of 4 KB pages.
    typedef struct packed {
        logic [VPN2_W-1:0]  vpn2;
        logic [ASID_W-1:0]  asid;
        logic               g;
        logic [PFN_W-1:0]   pfn0;
        logic [CACHE_W-1:0] c0;
        logic               d0;
        logic               v0;
        logic [PFN_W-1:0]   pfn1;
        logic [CACHE_W-1:0] c1;
        logic               d1;
        logic               v1;
    } tlb_entry_t;

    // page fields here belong to the page picked by vaddr bit 12.
    typedef struct packed {
        logic                   hit;
        logic [TLB_INDEX_W-1:0] index;
        logic [PFN_W-1:0]       pfn;
        logic [CACHE_W-1:0]     c;
        logic                   d;
        logic                   v;
        logic [31:0]            paddr;
    } tlb_match_t;

endpackage

// File: design/tu_seg_decode.sv
`timescale 1ns/1ns

module tu_seg_decode (
    input  logic [31:0] i_vaddr,
    input  logic        i_k0_uncached,
    output logic        o_mapped,
    output logic        o_uncached,
    output logic [31:0] o_paddr
);
    import tu_pkg::*;

    logic is_kuseg;
    logic is_kseg0;
    logic is_kseg1;
    logic is_kseg23;

    // kuseg is the lower half of the space, kseg2 and kseg3 the top quarter.
    assign is_kuseg  = ~i_vaddr[31];
    assign is_kseg0  = (i_vaddr[31:29] == 3'b100);
    assign is_kseg1  = (i_vaddr[31:29] == 3'b101);
    assign is_kseg23 = (i_vaddr[31:30] == 2'b11);

    assign o_mapped = is_kuseg | is_kseg23;

    // only meaningful when o_mapped is low.
    assign o_paddr = i_vaddr & KSEG_DIRECT_MASK;

    // kseg1 is never cached, kseg0 follows the config k0 field.
    assign o_uncached = is_kseg1 | (is_kseg0 & i_k0_uncached);

endmodule

// File: design/tlb_store.sv
`timescale 1ns/1ns

module tlb_store (
    input  logic                                          clk,
    input  logic                                          resetn,
    input  logic                                          i_we,
    input  logic [tu_pkg::TLB_INDEX_W-1:0]                i_waddr,
    input  logic [tu_pkg::TLB_INDEX_W-1:0]                i_raddr,
    input  tu_pkg::tlb_entry_t                            i_wentry,
    output tu_pkg::tlb_entry_t                            o_rentry,
    output tu_pkg::tlb_entry_t [tu_pkg::TLB_ENTRIES-1:0]  o_table
);
    import tu_pkg::*;

    tlb_entry_t [TLB_ENTRIES-1:0] table_q;
    logic       [TLB_ENTRIES-1:0] entry_we;

    // one-hot write select from the index register.
    always_comb begin
        entry_we = '0;
        if (i_we) begin
            entry_we[i_waddr] = 1'b1;
        end
    end

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_entry
        always_ff @(posedge clk) begin
            if (!resetn) begin
                table_q[i] <= '0; // a cleared entry has v0 and v1 low.
            end else if (entry_we[i]) begin
                table_q[i] <= i_wentry;
            end
        end
    end

    // tlbr reads straight out of the array.
    assign o_rentry = table_q[i_raddr];

    // the lookups see every entry at once.
    assign o_table = table_q;

    // a write with an unknown index would leave the whole table in doubt.
    property p_waddr_known;
        @(posedge clk) disable iff (!resetn)
        i_we |-> !$isunknown(i_waddr);
    endproperty

    a_waddr_known: assert property (p_waddr_known)
        else $error("tlbwi with unknown index %h", i_waddr);

endmodule

// File: design/tlb_lookup.sv
`timescale 1ns/1ns

module tlb_lookup (
    input  tu_pkg::tlb_entry_t [tu_pkg::TLB_ENTRIES-1:0] i_table,
    input  logic [31:0]                                  i_vaddr,
    input  logic [tu_pkg::ASID_W-1:0]                    i_asid,
    output tu_pkg::tlb_match_t                           o_match
);
    import tu_pkg::*;

    logic [TLB_ENTRIES-1:0] hit_mask;
    logic [TLB_INDEX_W-1:0] hit_idx;
    tlb_entry_t             sel;
    logic                   odd_page;

    // a global entry ignores the asid.
    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_cmp
        assign hit_mask[i] = (i_table[i].vpn2 == i_vaddr[31 -: VPN2_W]) &&
                             (i_table[i].g || (i_table[i].asid == i_asid));
    end

    // walk downwards so that the lowest matching index wins.
    always_comb begin
        hit_idx = '0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hit_mask[i]) begin
                hit_idx = TLB_INDEX_W'(i);
            end
        end
    end

    // on a miss this falls back to entry 0, and the caller looks at hit first.
    assign sel      = i_table[hit_idx];
    assign odd_page = i_vaddr[12];

    always_comb begin
        o_match.hit   = |hit_mask;
        o_match.index = hit_idx;
        if (odd_page) begin
            o_match.pfn = sel.pfn1;
            o_match.c   = sel.c1;
            o_match.d   = sel.d1;
            o_match.v   = sel.v1;
        end else begin
            o_match.pfn = sel.pfn0;
            o_match.c   = sel.c0;
            o_match.d   = sel.d0;
            o_match.v   = sel.v0;
        end
        o_match.paddr = {o_match.pfn, i_vaddr[11:0]}; // 4 KB pages only.
    end

endmodule

// File: design/tu_result.sv
`timescale 1ns/1ns

module tu_result (
    input  logic               clk,
    input  logic               resetn,
    input  logic               i_mapped,
    input  logic               i_seg_uncached,
    input  logic [31:0]        i_direct_paddr,
    input  tu_pkg::tlb_match_t i_match,
    output logic [31:0]        o_paddr,
    output logic               o_uncached,
    output logic               o_refill,
    output logic               o_invalid,
    output logic               o_modified
);
    import tu_pkg::*;

    logic               hit_q;
    logic               v_q;
    logic               d_q;
    logic [CACHE_W-1:0] c_q;
    logic [31:0]        paddr_q;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            hit_q <= 1'b0;
            v_q   <= 1'b0;
            d_q   <= 1'b0;
            c_q   <= '0;
        end else begin
            hit_q <= i_match.hit;
            v_q   <= i_match.v;
            d_q   <= i_match.d;
            c_q   <= i_match.c;
        end
    end

    always_ff @(posedge clk) begin
        paddr_q <= i_match.paddr;
    end

    // the direct path stays combinational, the tlb path is one cycle behind.
    assign o_paddr = i_mapped ? paddr_q : i_direct_paddr;

    // refill takes priority in the pipeline, so the other two may be set with it.
    assign o_refill   = i_mapped & ~hit_q;
    assign o_invalid  = i_mapped & ~v_q;
    assign o_modified = i_mapped & v_q & ~d_q;

    assign o_uncached = i_seg_uncached | (i_mapped & (c_q != CACHE_CACHEABLE));

    // a usable mapped translation always carries a known address.
    property p_paddr_known;
        @(posedge clk) disable iff (!resetn)
        (i_mapped && hit_q && v_q) |-> !$isunknown(o_paddr);
    endproperty

    a_paddr_known: assert property (p_paddr_known)
        else $error("mapped translation with unknown address %h", o_paddr);

endmodule

// File: design/translation_unit.sv
`timescale 1ns/1ns

module translation_unit (
    input  logic        clk,
    input  logic        resetn,
    input  logic        i_k0_uncached,
    input  logic [31:0] i_inst_vaddr,
    input  logic [31:0] i_data_vaddr,
    input  logic        i_tlbwi,
    input  logic [31:0] i_index,
    input  logic [31:0] i_entryhi,
    input  logic [31:0] i_entrylo0,
    input  logic [31:0] i_entrylo1,
    output logic [31:0] o_inst_paddr,
    output logic [31:0] o_data_paddr,
    output logic        o_i_uncached,
    output logic        o_d_uncached,
    output logic        o_i_mapped,
    output logic        o_d_mapped,
    output logic        o_i_refill,
    output logic        o_d_refill,
    output logic        o_i_invalid,
    output logic        o_d_invalid,
    output logic        o_i_modified,
    output logic        o_d_modified,
    output logic [31:0] o_entryhi,
    output logic [31:0] o_entrylo0,
    output logic [31:0] o_entrylo1,
    output logic [31:0] o_index
);
    import tu_pkg::*;

    logic                         inst_seg_uncached;
    logic                         data_seg_uncached;
    logic [31:0]                  inst_direct_paddr;
    logic [31:0]                  data_direct_paddr;
    logic [ASID_W-1:0]            cur_asid;
    tlb_entry_t                   wentry;
    tlb_entry_t                   rentry;
    tlb_entry_t [TLB_ENTRIES-1:0] tlb_table;
    tlb_match_t                   inst_match;
    tlb_match_t                   inst_match_fetch;
    tlb_match_t                   data_match;
    tlb_match_t                   probe_match;

    assign cur_asid = i_entryhi[ENTRYHI_ASID_LSB +: ASID_W];

    // tlbwi packs entryhi and the entrylo pair into one entry.
    always_comb begin
        wentry.vpn2 = i_entryhi[ENTRYHI_VPN2_LSB +: VPN2_W];
        wentry.asid = cur_asid;
        wentry.g    = i_entrylo0[ENTRYLO_G_BIT] & i_entrylo1[ENTRYLO_G_BIT];
        wentry.pfn0 = i_entrylo0[ENTRYLO_PFN_LSB +: PFN_W];
        wentry.c0   = i_entrylo0[ENTRYLO_C_LSB +: CACHE_W];
        wentry.d0   = i_entrylo0[ENTRYLO_D_BIT];
        wentry.v0   = i_entrylo0[ENTRYLO_V_BIT];
        wentry.pfn1 = i_entrylo1[ENTRYLO_PFN_LSB +: PFN_W];
        wentry.c1   = i_entrylo1[ENTRYLO_C_LSB +: CACHE_W];
        wentry.d1   = i_entrylo1[ENTRYLO_D_BIT];
        wentry.v1   = i_entrylo1[ENTRYLO_V_BIT];
    end

    tu_seg_decode u_inst_seg (
        .i_vaddr       (i_inst_vaddr),
        .i_k0_uncached (i_k0_uncached),
        .o_mapped      (o_i_mapped),
        .o_uncached    (inst_seg_uncached),
        .o_paddr       (inst_direct_paddr)
    );

    tu_seg_decode u_data_seg (
        .i_vaddr       (i_data_vaddr),
        .i_k0_uncached (i_k0_uncached),
        .o_mapped      (o_d_mapped),
        .o_uncached    (data_seg_uncached),
        .o_paddr       (data_direct_paddr)
    );

    tlb_store u_store (
        .clk      (clk),
        .resetn   (resetn),
        .i_we     (i_tlbwi),
        .i_waddr  (i_index[TLB_INDEX_W-1:0]),
        .i_raddr  (i_index[TLB_INDEX_W-1:0]),
        .i_wentry (wentry),
        .o_rentry (rentry),
        .o_table  (tlb_table)
    );

    tlb_lookup u_inst_lookup (
        .i_table (tlb_table),
        .i_vaddr (i_inst_vaddr),
        .i_asid  (cur_asid),
        .o_match (inst_match)
    );

    tlb_lookup u_data_lookup (
        .i_table (tlb_table),
        .i_vaddr (i_data_vaddr),
        .i_asid  (cur_asid),
        .o_match (data_match)
    );

    // tlbp reuses the lookup with entryhi standing in for the address.
    tlb_lookup u_probe_lookup (
        .i_table (tlb_table),
        .i_vaddr (i_entryhi),
        .i_asid  (cur_asid),
        .o_match (probe_match)
    );

    // fetch only honours the segment attribute, so its c is forced cacheable.
    always_comb begin
        inst_match_fetch   = inst_match;
        inst_match_fetch.c = CACHE_CACHEABLE;
    end

    tu_result u_inst_result (
        .clk            (clk),
        .resetn         (resetn),
        .i_mapped       (o_i_mapped),
        .i_seg_uncached (inst_seg_uncached),
        .i_direct_paddr (inst_direct_paddr),
        .i_match        (inst_match_fetch),
        .o_paddr        (o_inst_paddr),
        .o_uncached     (o_i_uncached),
        .o_refill       (o_i_refill),
        .o_invalid      (o_i_invalid),
        .o_modified     (o_i_modified)
    );

    tu_result u_data_result (
        .clk            (clk),
        .resetn         (resetn),
        .i_mapped       (o_d_mapped),
        .i_seg_uncached (data_seg_uncached),
        .i_direct_paddr (data_direct_paddr),
        .i_match        (data_match),
        .o_paddr        (o_data_paddr),
        .o_uncached     (o_d_uncached),
        .o_refill       (o_d_refill),
        .o_invalid      (o_d_invalid),
        .o_modified     (o_d_modified)
    );

    // tlbr unpacks the entry, and both entrylo words carry the same g.
    always_comb begin
        o_entryhi  = '0;
        o_entrylo0 = '0;
        o_entrylo1 = '0;
        o_entryhi[ENTRYHI_VPN2_LSB +: VPN2_W] = rentry.vpn2;
        o_entryhi[ENTRYHI_ASID_LSB +: ASID_W] = rentry.asid;
        o_entrylo0[ENTRYLO_PFN_LSB +: PFN_W]  = rentry.pfn0;
        o_entrylo0[ENTRYLO_C_LSB +: CACHE_W]  = rentry.c0;
        o_entrylo0[ENTRYLO_D_BIT]             = rentry.d0;
        o_entrylo0[ENTRYLO_V_BIT]             = rentry.v0;
        o_entrylo0[ENTRYLO_G_BIT]             = rentry.g;
        o_entrylo1[ENTRYLO_PFN_LSB +: PFN_W]  = rentry.pfn1;
        o_entrylo1[ENTRYLO_C_LSB +: CACHE_W]  = rentry.c1;
        o_entrylo1[ENTRYLO_D_BIT]             = rentry.d1;
        o_entrylo1[ENTRYLO_V_BIT]             = rentry.v1;
        o_entrylo1[ENTRYLO_G_BIT]             = rentry.g;
    end

    always_comb begin
        o_index = '0;
        o_index[INDEX_P_BIT]         = ~probe_match.hit; // probe failure.
        o_index[TLB_INDEX_W-1:0]     = probe_match.index;
    end

endmodule

// File: testbench/tu_model.svh
`ifndef TU_MODEL_SVH
`define TU_MODEL_SVH

// shadow of the tlb, kept as the cp0 words that tlbr should return.
logic [31:0] model_hi  [16];
logic [31:0] model_lo0 [16];
logic [31:0] model_lo1 [16];

task automatic model_reset();
    for (int i = 0; i < 16; i++) begin
        model_hi[i]  = '0;
        model_lo0[i] = '0;
        model_lo1[i] = '0;
    end
endtask

// entryhi bits 12:8 and entrylo bits 31:26 are not stored and read back as zero.
task automatic model_write(input logic [3:0] idx, input logic [31:0] hi,
                           input logic [31:0] lo0, input logic [31:0] lo1);
    logic g;
    g = lo0[0] & lo1[0]; // an entry is global only if both halves say so.
    model_hi[idx]  = hi & 32'hffff_e0ff;
    model_lo0[idx] = (lo0 & 32'h03ff_fffe) | {31'b0, g};
    model_lo1[idx] = (lo1 & 32'h03ff_fffe) | {31'b0, g};
endtask

// the first entry with equal vpn2 and equal asid or g set wins.
task automatic model_lookup(input logic [31:0] vaddr, input logic [7:0] asid,
                            output logic hit, output logic [3:0] idx,
                            output logic [31:0] lo);
    hit = 1'b0;
    idx = '0;
    lo  = '0;
    for (int i = 0; i < 16; i++) begin
        if (!hit && model_hi[i][31:13] == vaddr[31:13] &&
            (model_lo0[i][0] || model_hi[i][7:0] == asid)) begin
            hit = 1'b1;
            idx = 4'(i);
            lo  = vaddr[12] ? model_lo1[i] : model_lo0[i]; // bit 12 picks the odd page.
        end
    end
endtask

function automatic logic seg_mapped(input logic [31:0] vaddr);
    return !vaddr[31] || (vaddr[31:30] == 2'b11);
endfunction

// kseg1 is never cached, kseg0 only when k0 says so.
function automatic logic seg_uncached(input logic [31:0] vaddr, input logic k0_unc);
    return (vaddr[31:29] == 3'b101) || ((vaddr[31:29] == 3'b100) && k0_unc);
endfunction

`endif

// File: testbench/tb_translation_unit.sv
`timescale 1ns/1ns

module tb_translation_unit;

    localparam int CLK_PERIOD = 100;
    localparam int N_WRITE    = 40;
    localparam int N_PROBE    = 60;
    localparam int N_DIRECT   = 60;
    localparam int N_MAPPED   = 120;
    localparam int RUN_CYCLES = 2 + 2 * N_WRITE + N_PROBE + N_DIRECT + 2 * (N_MAPPED + 1);
    localparam int TIMEOUT_NS = (RUN_CYCLES + 20) * CLK_PERIOD;

    logic        clk;
    logic        resetn;
    logic        i_k0_uncached;
    logic        i_tlbwi;
    logic [31:0] i_inst_vaddr, i_data_vaddr, i_index;
    logic [31:0] i_entryhi, i_entrylo0, i_entrylo1;
    logic [31:0] o_inst_paddr, o_data_paddr;
    logic        o_i_uncached, o_d_uncached, o_i_mapped, o_d_mapped;
    logic        o_i_refill, o_d_refill, o_i_invalid, o_d_invalid;
    logic        o_i_modified, o_d_modified;
    logic [31:0] o_entryhi, o_entrylo0, o_entrylo1, o_index;

    int errors = 0;
    int test_start_errors = 0;
    int tests_done = 0;

    `include "tu_model.svh"

    translation_unit dut (
        .clk           (clk),
        .resetn        (resetn),
        .i_k0_uncached (i_k0_uncached),
        .i_inst_vaddr  (i_inst_vaddr),
        .i_data_vaddr  (i_data_vaddr),
        .i_tlbwi       (i_tlbwi),
        .i_index       (i_index),
        .i_entryhi     (i_entryhi),
        .i_entrylo0    (i_entrylo0),
        .i_entrylo1    (i_entrylo1),
        .o_inst_paddr  (o_inst_paddr),
        .o_data_paddr  (o_data_paddr),
        .o_i_uncached  (o_i_uncached),
        .o_d_uncached  (o_d_uncached),
        .o_i_mapped    (o_i_mapped),
        .o_d_mapped    (o_d_mapped),
        .o_i_refill    (o_i_refill),
        .o_d_refill    (o_d_refill),
        .o_i_invalid   (o_i_invalid),
        .o_d_invalid   (o_d_invalid),
        .o_i_modified  (o_i_modified),
        .o_d_modified  (o_d_modified),
        .o_entryhi     (o_entryhi),
        .o_entrylo0    (o_entrylo0),
        .o_entrylo1    (o_entrylo1),
        .o_index       (o_index)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("watchdog expired after %0d ns, the tests did not finish", TIMEOUT_NS);
        $display("TB FAILED");
        $finish;
    end

    task automatic report_error(input string msg);
        errors++;
        $display("FAILED @%0t ns: %s", $time, msg);
    endtask

    task automatic end_test(input string name);
        $display("test %s finished with %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
        tests_done++;
    endtask

    // small pools, so that entries collide, alias and miss.
    function automatic logic [18:0] pick_vpn2();
        case ($urandom_range(5))
            0: return 19'h00001;
            1: return 19'h00002;
            2: return 19'h01234;
            3: return 19'h60000;
            4: return 19'h7ffff;
            default: return 19'h60abc;
        endcase
    endfunction

    function automatic logic [7:0] pick_asid();
        case ($urandom_range(3))
            0: return 8'h00;
            1: return 8'h01;
            2: return 8'h2a;
            default: return 8'hff;
        endcase
    endfunction

    function automatic logic [31:0] rand_entryhi();
        return {pick_vpn2(), 5'($urandom), pick_asid()}; // junk in the unused bits.
    endfunction

    function automatic logic [31:0] rand_mapped_vaddr();
        logic [31:0] va;
        va = $urandom;
        if ($urandom_range(3) != 0) begin
            va[31:13] = pick_vpn2();
        end else if (va[31:30] == 2'b10) begin
            va[31] = 1'b0; // keep the random miss out of kseg0/1.
        end
        return va;
    endfunction

    task automatic check_direct(input string port, input logic [31:0] va,
                                input logic [31:0] paddr, input logic mapped,
                                input logic unc, input logic flags);
        if (paddr !== (va & 32'h1fff_ffff)) begin
            report_error($sformatf("%s paddr %h for va %h", port, paddr, va));
        end
        if (mapped !== seg_mapped(va) || flags !== 1'b0) begin
            report_error($sformatf("%s mapped or flags set for va %h", port, va));
        end
        if (unc !== seg_uncached(va, i_k0_uncached)) begin
            report_error($sformatf("%s uncached %b for va %h", port, unc, va));
        end
    endtask

    // on a miss only refill is defined, plus the fetch attribute.
    task automatic check_mapped(input string port, input logic is_data, input logic flags,
                                input logic [31:0] va, input logic [31:0] paddr,
                                input logic mapped, input logic unc, input logic refill,
                                input logic invalid, input logic modified);
        logic        hit;
        logic [3:0]  idx;
        logic [31:0] lo;
        logic        exp_unc;
        model_lookup(va, i_entryhi[7:0], hit, idx, lo);
        exp_unc = is_data && (lo[5:3] != 3'd3);
        if (!flags && (mapped !== seg_mapped(va) ||
                       (hit && paddr !== {lo[25:6], va[11:0]}))) begin
            report_error($sformatf("%s va %h gave paddr %h mapped %b", port, va, paddr, mapped));
        end
        if (flags && (refill !== !hit || (hit && invalid !== !lo[1]))) begin
            report_error($sformatf("%s va %h refill %b invalid %b", port, va, refill, invalid));
        end
        if (flags && hit && modified !== (lo[1] && !lo[2])) begin
            report_error($sformatf("%s va %h modified %b", port, va, modified));
        end
        if (flags && (hit || !is_data) && unc !== exp_unc) begin
            report_error($sformatf("%s va %h uncached %b", port, va, unc));
        end
    endtask

    // each result is checked one cycle after its address, before the next one goes in.
    task automatic run_mapped(input logic flags);
        for (int n = 0; n <= N_MAPPED; n++) begin
            if (n > 0) begin
                check_mapped("inst", 1'b0, flags, i_inst_vaddr, o_inst_paddr, o_i_mapped,
                             o_i_uncached, o_i_refill, o_i_invalid, o_i_modified);
                check_mapped("data", 1'b1, flags, i_data_vaddr, o_data_paddr, o_d_mapped,
                             o_d_uncached, o_d_refill, o_d_invalid, o_d_modified);
            end
            i_inst_vaddr = rand_mapped_vaddr();
            i_data_vaddr = rand_mapped_vaddr();
            i_entryhi    = rand_entryhi();
            @(negedge clk);
        end
    endtask

    initial begin
        int unsigned rng_seed;
        logic [3:0]  idx;
        logic        hit;
        logic [31:0] lo;
        rng_seed = 32'h6e06_1c93;
        void'($urandom(rng_seed));
        resetn = 1'b0;
        i_k0_uncached = 1'b0;
        i_tlbwi = 1'b0;
        i_inst_vaddr = '0;
        i_data_vaddr = '0;
        i_index = '0;
        i_entryhi = '0;
        i_entrylo0 = '0;
        i_entrylo1 = '0;
        model_reset();
        repeat (2) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;

        for (int n = 0; n < N_WRITE; n++) begin
            idx = 4'($urandom);
            i_index = {28'b0, idx};
            i_entryhi = rand_entryhi();
            i_entrylo0 = $urandom;
            i_entrylo1 = $urandom;
            i_tlbwi = 1'b1;
            @(negedge clk);
            model_write(idx, i_entryhi, i_entrylo0, i_entrylo1);
            i_tlbwi = 1'b0;
            @(negedge clk);
            if (o_entryhi !== model_hi[idx] || o_entrylo0 !== model_lo0[idx] ||
                o_entrylo1 !== model_lo1[idx]) begin
                report_error($sformatf("tlbr index %0d gave %h %h %h", idx, o_entryhi,
                                       o_entrylo0, o_entrylo1));
            end
        end
        end_test("write_read");

        for (int n = 0; n < N_PROBE; n++) begin
            i_entryhi = ($urandom_range(3) == 0) ? $urandom : rand_entryhi();
            @(negedge clk);
            model_lookup(i_entryhi, i_entryhi[7:0], hit, idx, lo);
            if ((hit && o_index !== {28'b0, idx}) || (!hit && o_index[31] !== 1'b1)) begin
                report_error($sformatf("tlbp %h gave index %h", i_entryhi, o_index));
            end
        end
        end_test("probe");

        for (int n = 0; n < N_DIRECT; n++) begin
            i_inst_vaddr = {2'b10, 30'($urandom)};
            i_data_vaddr = {2'b10, 30'($urandom)};
            i_k0_uncached = $urandom_range(1);
            @(negedge clk);
            check_direct("inst", i_inst_vaddr, o_inst_paddr, o_i_mapped, o_i_uncached,
                         o_i_refill | o_i_invalid | o_i_modified);
            check_direct("data", i_data_vaddr, o_data_paddr, o_d_mapped, o_d_uncached,
                         o_d_refill | o_d_invalid | o_d_modified);
        end
        end_test("direct");

        run_mapped(1'b0);
        end_test("mapped");
        run_mapped(1'b1);
        end_test("flags");

        $display("tests run: %0d, errors: %0d", tests_done, errors);
        if (errors == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

// File: files.f
+incdir+testbench
design/tu_pkg.sv
design/tu_seg_decode.sv
design/tlb_store.sv
design/tlb_lookup.sv
design/tu_result.sv
design/translation_unit.sv
testbench/tb_translation_unit.sv
